//--- source/noc_pkg.sv
/* Shared constants, types and XY routing for the 2x2 mesh NoC.
 * Single channel, no virtual channels. Tile index bit 0 is x, bit 1 is y.
 * Header flit layout assumes FLIT_WIDTH of 32 with destination in the top bits.
 */
package noc_pkg;

   // Flit payload width, last bit travels beside it
   localparam int FLIT_WIDTH = 32;

   // Mesh size
   localparam int NUM_TILES     = 4;
   localparam int TILE_ID_WIDTH = 2;

   // Header field positions, both fields TILE_ID_WIDTH wide
   localparam int DEST_MSB = 31;
   localparam int SRC_MSB  = 29;

   // Entries per router input buffer
   localparam int BUFFER_DEPTH = 4;

   // Router ports and their indices
   localparam int NUM_PORTS = 3;
   localparam logic [1:0] PORT_LOCAL = 2'd0;
   localparam logic [1:0] PORT_X     = 2'd1;
   localparam logic [1:0] PORT_Y     = 2'd2;

   // Bit 0 is the x coordinate, bit 1 the y coordinate
   typedef logic [TILE_ID_WIDTH-1:0] tile_id_t;

   // Dimension-ordered routing
   // X is resolved first, then Y, then the packet is ejected
   function automatic logic [1:0] route_port(input tile_id_t here, input tile_id_t dest);
      logic [1:0] port;
      if (here[0] != dest[0]) begin
         port = PORT_X;
      end else if (here[1] != dest[1]) begin
         port = PORT_Y;
      end else begin
         port = PORT_LOCAL;
      end
      return port;
   endfunction

endpackage

//--- source/noc_link_if.sv
/* One unidirectional flit link with valid/ready handshake.
 * A flit moves on the rising clk edge with valid and ready high.
 * Valid, flit and last hold until the transfer happens.
 */
`timescale 1ns/1ps

interface noc_link_if;

   // Payload
   logic [noc_pkg::FLIT_WIDTH-1:0] flit;
   // Marks the final flit of a packet
   logic last;

   // Handshake
   logic valid;
   logic ready;

   // Upstream side of the link
   modport sender (
      output flit,
      output last,
      output valid,
      input  ready
   );

   // Downstream side, ready depends only on its own state
   modport receiver (
      input  flit,
      input  last,
      input  valid,
      output ready
   );

endinterface

//--- source/noc_input_buffer.sv
/* Circular flit FIFO with valid/ready on both sides.
 * Depth comes from noc_pkg::BUFFER_DEPTH, any depth of one or more works.
 * Ready is high while not full; a write is seen at the head one edge later.
 * Storage is not cleared by reset, only pointers and fill count.
 */
`timescale 1ns/1ps

module noc_input_buffer (
   input  logic                           clk,
   input  logic                           rst_n_i,
   input  logic [noc_pkg::FLIT_WIDTH-1:0] in_flit_i,
   input  logic                           in_last_i,
   input  logic                           in_valid_i,
   output logic                           in_ready_o,
   output logic [noc_pkg::FLIT_WIDTH-1:0] out_flit_o,
   output logic                           out_last_o,
   output logic                           out_valid_o,
   input  logic                           out_ready_i
);

   localparam int DEPTH = noc_pkg::BUFFER_DEPTH;
   localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW    = $clog2(DEPTH + 1);

   // Each entry holds last on top of the flit
   logic [noc_pkg::FLIT_WIDTH:0] entry_mem [DEPTH];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [CW-1:0] count;
   logic          push;
   logic          pop;

   // Handshake from fill level only
   assign in_ready_o  = (count != CW'(DEPTH));
   assign out_valid_o = (count != '0);

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   // Head of queue straight from storage
   assign out_flit_o = entry_mem[rd_ptr][noc_pkg::FLIT_WIDTH-1:0];
   assign out_last_o = entry_mem[rd_ptr][noc_pkg::FLIT_WIDTH];

   always_ff @(posedge clk) begin
      if (push) begin
         entry_mem[wr_ptr] <= {in_last_i, in_flit_i};
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Pointers wrap at DEPTH, not at a power of two
         if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // Read and write together leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

//--- source/noc_router.sv
/* Three-port wormhole router: local, X and Y, one channel.
 * Headers route by XY on the destination field of the head flit.
 * Output grant is registered, so a header waits one edge at the buffer head.
 * An output stays locked to one input until the flit with last set moves.
 * One idle cycle per output between back-to-back packets.
 */
`timescale 1ns/1ps

module noc_router #(
   parameter noc_pkg::tile_id_t TILE_ID = '0
) (
   input  logic         clk,
   input  logic         rst_n_i,
   noc_link_if.receiver in_link_i  [noc_pkg::NUM_PORTS],
   noc_link_if.sender   out_link_o [noc_pkg::NUM_PORTS]
);

   localparam int P  = noc_pkg::NUM_PORTS;
   localparam int PW = $clog2(noc_pkg::NUM_PORTS);

   // Buffer heads, one per input
   logic [noc_pkg::FLIT_WIDTH-1:0] head_flit [P];
   logic [P-1:0]                   head_last;
   logic [P-1:0]                   head_valid;
   logic [P-1:0]                   head_ready;
   // Output requested by the header at each head
   logic [PW-1:0]                  head_port [P];
   // Input currently streaming a packet through some output
   logic [P-1:0]                   in_owned;

   // Output side handshake
   logic [P-1:0]                   out_valid;
   logic [P-1:0]                   out_ready;
   logic [P-1:0]                   out_last;

   // Per output lock and round-robin state
   logic [P-1:0]                   out_locked;
   logic [PW-1:0]                  out_owner [P];
   logic [PW-1:0]                  rr_ptr [P];
   logic [P-1:0]                   grant_valid;
   logic [PW-1:0]                  grant_idx [P];

   for (genvar i = 0; i < P; i++) begin : gen_input
      noc_input_buffer u_buffer (
         .clk         (clk),
         .rst_n_i     (rst_n_i),
         .in_flit_i   (in_link_i[i].flit),
         .in_last_i   (in_link_i[i].last),
         .in_valid_i  (in_link_i[i].valid),
         .in_ready_o  (in_link_i[i].ready),
         .out_flit_o  (head_flit[i]),
         .out_last_o  (head_last[i]),
         .out_valid_o (head_valid[i]),
         .out_ready_i (head_ready[i])
      );

      // Only meaningful while the head is a header
      assign head_port[i] = noc_pkg::route_port(
         TILE_ID,
         head_flit[i][noc_pkg::DEST_MSB -: noc_pkg::TILE_ID_WIDTH]
      );
   end

   // Switch, the owner's head drives a locked output
   for (genvar o = 0; o < P; o++) begin : gen_output
      assign out_valid[o] = out_locked[o] & head_valid[out_owner[o]];
      assign out_last[o]  = head_last[out_owner[o]];
      assign out_ready[o] = out_link_o[o].ready;

      assign out_link_o[o].valid = out_valid[o];
      assign out_link_o[o].flit  = head_flit[out_owner[o]];
      assign out_link_o[o].last  = out_last[o];
   end

   // Return path, output ready goes back to its owner only
   always_comb begin
      in_owned   = '0;
      head_ready = '0;
      for (int o = 0; o < P; o++) begin
         if (out_locked[o]) begin
            in_owned[out_owner[o]]   = 1'b1;
            head_ready[out_owner[o]] = out_ready[o];
         end
      end
   end

   // Round-robin pick among idle inputs whose header wants this output
   // Search starts at the input after the last winner
   always_comb begin
      int idx;
      for (int o = 0; o < P; o++) begin
         grant_valid[o] = 1'b0;
         grant_idx[o]   = rr_ptr[o];
         for (int k = 0; k < P; k++) begin
            idx = int'(rr_ptr[o]) + k;
            if (idx >= P) begin
               idx = idx - P;
            end
            if (!grant_valid[o] && head_valid[idx] && !in_owned[idx] &&
                (int'(head_port[idx]) == o)) begin
               grant_valid[o] = 1'b1;
               grant_idx[o]   = PW'(idx);
            end
         end
      end
   end

   // Lock on grant, release on the edge that moves the tail flit
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         out_locked <= '0;
         for (int o = 0; o < P; o++) begin
            out_owner[o] <= '0;
            rr_ptr[o]    <= '0;
         end
      end else begin
         for (int o = 0; o < P; o++) begin
            if (out_locked[o]) begin
               if (out_valid[o] && out_ready[o] && out_last[o]) begin
                  out_locked[o] <= 1'b0;
               end
            end else if (grant_valid[o]) begin
               out_locked[o] <= 1'b1;
               out_owner[o]  <= grant_idx[o];
               rr_ptr[o]     <= (int'(grant_idx[o]) == P - 1) ? '0 : grant_idx[o] + 1'b1;
            end
         end
      end
   end

endmodule

//--- source/system_2x2_noc.sv
/* 2x2 mesh of wormhole routers, tile t at x = t[0], y = t[1].
 * Each tile's local port is brought out as plain inject and eject ports.
 * Inner links are per-router sender and receiver interfaces joined by the
 * tx and rx nets below, which also serve as link monitor points.
 */
`timescale 1ns/1ps

module system_2x2_noc (
   input  logic                                                 clk,
   input  logic                                                 rst_n_i,
   input  logic [noc_pkg::NUM_TILES-1:0][noc_pkg::FLIT_WIDTH-1:0] inj_flit_i,
   input  logic [noc_pkg::NUM_TILES-1:0]                        inj_last_i,
   input  logic [noc_pkg::NUM_TILES-1:0]                        inj_valid_i,
   output logic [noc_pkg::NUM_TILES-1:0]                        inj_ready_o,
   output logic [noc_pkg::NUM_TILES-1:0][noc_pkg::FLIT_WIDTH-1:0] ej_flit_o,
   output logic [noc_pkg::NUM_TILES-1:0]                        ej_last_o,
   output logic [noc_pkg::NUM_TILES-1:0]                        ej_valid_o,
   input  logic [noc_pkg::NUM_TILES-1:0]                        ej_ready_i
);

   localparam int T = noc_pkg::NUM_TILES;
   localparam int P = noc_pkg::NUM_PORTS;

   // Router outputs, indexed by tile then port
   logic [T-1:0][P-1:0][noc_pkg::FLIT_WIDTH-1:0] tx_flit;
   logic [T-1:0][P-1:0]                          tx_last;
   logic [T-1:0][P-1:0]                          tx_valid;
   // Router input readies, indexed the same way
   logic [T-1:0][P-1:0]                          rx_ready;

   for (genvar t = 0; t < T; t++) begin : gen_tile
      noc_link_if rx_link [P] ();
      noc_link_if tx_link [P] ();

      for (genvar p = 0; p < P; p++) begin : gen_port
         assign tx_flit[t][p]  = tx_link[p].flit;
         assign tx_last[t][p]  = tx_link[p].last;
         assign tx_valid[t][p] = tx_link[p].valid;
         assign rx_ready[t][p] = rx_link[p].ready;
      end

      // Injection side of the local port
      assign rx_link[noc_pkg::PORT_LOCAL].flit  = inj_flit_i[t];
      assign rx_link[noc_pkg::PORT_LOCAL].last  = inj_last_i[t];
      assign rx_link[noc_pkg::PORT_LOCAL].valid = inj_valid_i[t];
      assign inj_ready_o[t] = rx_ready[t][noc_pkg::PORT_LOCAL];

      // Ejection side of the local port
      assign ej_flit_o[t]  = tx_flit[t][noc_pkg::PORT_LOCAL];
      assign ej_last_o[t]  = tx_last[t][noc_pkg::PORT_LOCAL];
      assign ej_valid_o[t] = tx_valid[t][noc_pkg::PORT_LOCAL];
      assign tx_link[noc_pkg::PORT_LOCAL].ready = ej_ready_i[t];

      // X neighbor differs in bit 0, Y neighbor in bit 1
      // A port always faces the same port of its neighbor
      for (genvar p = noc_pkg::PORT_X; p <= noc_pkg::PORT_Y; p++) begin : gen_mesh
         localparam int NB = (p == noc_pkg::PORT_X) ? (t ^ 1) : (t ^ 2);

         assign rx_link[p].flit  = tx_flit[NB][p];
         assign rx_link[p].last  = tx_last[NB][p];
         assign rx_link[p].valid = tx_valid[NB][p];
         assign tx_link[p].ready = rx_ready[NB][p];
      end

      noc_router #(
         .TILE_ID (noc_pkg::tile_id_t'(t))
      ) u_router (
         .clk        (clk),
         .rst_n_i    (rst_n_i),
         .in_link_i  (rx_link),
         .out_link_o (tx_link)
      );
   end

endmodule

//--- verif/tb_system_2x2_noc.sv
/* Testbench for the 2x2 mesh NoC, driven through the plain tile ports.
 * Inputs change 1 ns after the rising edge and outputs are sampled at the falling edge.
 * Header flit holds destination, source and a 28-bit sequence number per pair.
 * Scoreboard holds at most 256 flits per pair over the whole run.
 */
`timescale 1ns/1ps

module tb_system_2x2_noc;

   localparam int T = noc_pkg::NUM_TILES;
   localparam int W = noc_pkg::FLIT_WIDTH;
   localparam int TW = noc_pkg::TILE_ID_WIDTH;
   // About 300 flits in all with the slowest phase at half rate over two hops
   localparam int MAX_CYCLES = 4000;
   localparam int SB_DEPTH = 256;

   logic                clk;
   logic                rst_n_i;
   logic [T-1:0][W-1:0] inj_flit_i;
   logic [T-1:0]        inj_last_i;
   logic [T-1:0]        inj_valid_i;
   logic [T-1:0]        inj_ready_o;
   logic [T-1:0][W-1:0] ej_flit_o;
   logic [T-1:0]        ej_last_o;
   logic [T-1:0]        ej_valid_o;
   logic [T-1:0]        ej_ready_i;

   // Expected {last, flit} words in one FIFO per pair at source * T + destination
   logic [W:0]          expect_mem [T*T][SB_DEPTH];
   int                  head_idx [T*T];
   int                  tail_idx [T*T];
   int                  seq_num [T*T];
   int                  rx_seq [T*T];
   int                  pending;
   int                  body_count;

   // Ejection monitor state per tile
   logic [T-1:0]        in_packet;
   logic [TW-1:0]       cur_src [T];
   logic [T-1:0]        hold_pending;
   logic [W:0]          hold_word [T];

   // Back-pressure control for one destination
   logic                bp_active;
   logic                bp_hold;
   int                  bp_tile;

   int                  err_mismatch;
   int                  err_other;
   int                  cycle_count;
   string               test_name;

   system_2x2_noc uut (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .inj_flit_i  (inj_flit_i),
      .inj_last_i  (inj_last_i),
      .inj_valid_i (inj_valid_i),
      .inj_ready_o (inj_ready_o),
      .ej_flit_o   (ej_flit_o),
      .ej_last_o   (ej_last_o),
      .ej_valid_o  (ej_valid_o),
      .ej_ready_i  (ej_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   task automatic flag_mismatch(input int tile, input logic [W:0] exp, input logic [W:0] act);
      $display("FAILED %s: tile %0d expected %h actual %h", test_name, tile, exp, act);
      err_mismatch++;
   endtask

   task automatic flag_problem(input string msg);
      $display("Error in %s: %s", test_name, msg);
      err_other++;
   endtask

   task automatic push_expected(input int pair, input logic [W:0] word);
      if (tail_idx[pair] >= SB_DEPTH) begin
         flag_problem($sformatf("scoreboard full for pair %0d", pair));
      end else begin
         expect_mem[pair][tail_idx[pair]] = word;
         tail_idx[pair]++;
         pending++;
      end
   endtask

   // Called at +1 ns and returns at +1 ns after the edge that takes the tail flit
   task automatic send_packet(input int src, input int dst, input int len);
      logic [W-1:0] flit;
      logic         accepted;
      int           pair;
      pair = src * T + dst;
      for (int i = 0; i < len; i++) begin
         flit = '0;
         flit[noc_pkg::DEST_MSB -: TW] = dst[TW-1:0];
         flit[noc_pkg::SRC_MSB -: TW]  = src[TW-1:0];
         if (i == 0) begin
            flit[27:0] = 28'(seq_num[pair]);
         end else begin
            // Body keeps the source and a running count
            flit[27:16] = 12'(seq_num[pair]);
            flit[15:0]  = 16'(body_count);
            body_count++;
         end
         push_expected(pair, {(i == len - 1), flit});
         inj_flit_i[src]  = flit;
         inj_last_i[src]  = (i == len - 1);
         inj_valid_i[src] = 1'b1;
         accepted = 1'b0;
         while (!accepted) begin
            // Ready only moves on an edge, so it holds until the next one
            accepted = inj_ready_o[src];
            @(posedge clk);
            #1;
         end
      end
      inj_valid_i[src] = 1'b0;
      inj_last_i[src]  = 1'b0;
      seq_num[pair]++;
   endtask

   // Negative dst picks a random destination per packet
   task automatic send_stream(input int src, input int count, input int dst, input int min_len);
      int target;
      int len;
      int gap;
      for (int n = 0; n < count; n++) begin
         target = (dst < 0) ? int'($urandom_range(T - 1, 0)) : dst;
         len    = int'($urandom_range(4, min_len));
         send_packet(src, target, len);
         gap = int'($urandom_range(2, 0));
         repeat (gap) begin
            @(posedge clk);
            #1;
         end
      end
   endtask

   // One single-flit packet to every tile including itself
   task automatic send_all_dests(input int src);
      for (int d = 0; d < T; d++) begin
         send_packet(src, d, 1);
      end
   endtask

   task automatic wait_drain();
      while (pending != 0) begin
         @(posedge clk);
      end
      #1;
      assert (in_packet == '0) else flag_problem("packet left open after drain");
   endtask

   task automatic check_idle(input string when);
      assert (ej_valid_o == '0) else flag_problem({"ej_valid_o high ", when});
      assert (inj_ready_o == '1) else flag_problem({"inj_ready_o low ", when});
   endtask

   // Runs at the falling edge, where outputs match the next rising edge
   task automatic check_tile(input int t);
      logic [W:0]    got;
      logic [TW-1:0] src;
      int            pair;
      got = {ej_last_o[t], ej_flit_o[t]};
      // Stalled output must keep valid, flit and last
      if (hold_pending[t]) begin
         assert (ej_valid_o[t] && got == hold_word[t])
            else flag_problem($sformatf("tile %0d output changed while stalled", t));
      end
      hold_pending[t] = ej_valid_o[t] & ~ej_ready_i[t];
      hold_word[t]    = got;
      if (ej_valid_o[t] && ej_ready_i[t]) begin
         if (!in_packet[t]) begin
            src  = got[noc_pkg::SRC_MSB -: TW];
            pair = int'(src) * T + t;
            assert (got[noc_pkg::DEST_MSB -: TW] == t[TW-1:0])
               else flag_problem($sformatf("header for tile %0d came out at tile %0d",
                                           got[noc_pkg::DEST_MSB -: TW], t));
            // Headers of one pair arrive in send order
            assert (got[27:0] == 28'(rx_seq[pair]))
               else flag_problem($sformatf("tile %0d got sequence %0d from %0d, wanted %0d",
                                           t, got[27:0], src, rx_seq[pair]));
            rx_seq[pair]++;
         end else begin
            src  = cur_src[t];
            pair = int'(src) * T + t;
            assert (got[noc_pkg::SRC_MSB -: TW] == src)
               else flag_problem($sformatf("tile %0d got a flit of another packet inside one", t));
         end
         if (head_idx[pair] == tail_idx[pair]) begin
            flag_problem($sformatf("unexpected flit %h at tile %0d", got, t));
         end else begin
            assert (got == expect_mem[pair][head_idx[pair]])
               else flag_mismatch(t, expect_mem[pair][head_idx[pair]], got);
            head_idx[pair]++;
            pending--;
         end
         in_packet[t] = ~got[W];
         cur_src[t]   = src;
      end
   endtask

   always @(negedge clk) begin
      if (rst_n_i) begin
         for (int t = 0; t < T; t++) begin
            check_tile(t);
         end
      end
   end

   // Flags are read at the edge and the new ready goes out 1 ns later
   initial begin
      logic          active;
      logic          hold;
      logic [T-1:0]  next_ready;
      forever begin
         @(posedge clk);
         active = bp_active;
         hold   = bp_hold;
         #1;
         next_ready = '1;
         if (active) begin
            next_ready[bp_tile] = hold ? 1'b0 : 1'($urandom_range(1, 0));
         end
         ej_ready_i = next_ready;
      end
   end

   initial begin
      cycle_count = 0;
      while (cycle_count < MAX_CYCLES) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("Timeout after %0d cycles with %0d flits still expected", MAX_CYCLES, pending);
      $display("Errors: %0d value mismatches, %0d other failures", err_mismatch, err_other);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      void'($urandom(65819));
      rst_n_i      = 1'b0;
      inj_flit_i   = '0;
      inj_last_i   = '0;
      inj_valid_i  = '0;
      ej_ready_i   = '1;
      bp_active    = 1'b0;
      bp_hold      = 1'b0;
      bp_tile      = 0;
      pending      = 0;
      body_count   = 0;
      err_mismatch = 0;
      err_other    = 0;
      in_packet    = '0;
      hold_pending = '0;
      for (int p = 0; p < T * T; p++) begin
         head_idx[p] = 0;
         tail_idx[p] = 0;
         seq_num[p]  = 0;
         rx_seq[p]   = 0;
      end
      for (int t = 0; t < T; t++) begin
         cur_src[t]   = '0;
         hold_word[t] = '0;
      end

      // Two reset edges, then one cycle checked after release
      test_name = "reset";
      @(posedge clk);
      @(negedge clk);
      check_idle("during reset");
      @(posedge clk);
      #1;
      rst_n_i = 1'b1;
      @(negedge clk);
      check_idle("right after reset");
      @(posedge clk);
      #1;

      test_name = "single_flit";
      fork
         send_all_dests(0);
         send_all_dests(1);
         send_all_dests(2);
         send_all_dests(3);
      join
      wait_drain();

      // All sources converge on tile 0 with multi-flit packets
      test_name = "wormhole";
      fork
         send_stream(0, 3, 0, 2);
         send_stream(1, 3, 0, 2);
         send_stream(2, 3, 0, 2);
         send_stream(3, 3, 0, 2);
      join
      wait_drain();

      test_name = "ordering";
      fork
         send_stream(3, 8, 0, 1);
         send_stream(2, 8, 1, 1);
      join
      wait_drain();

      // Long stall first so buffers back up to the injectors
      test_name = "back_pressure";
      bp_tile   = 2;
      bp_active = 1'b1;
      bp_hold   = 1'b1;
      fork
         send_stream(0, 4, 2, 1);
         send_stream(1, 4, 2, 1);
         send_stream(3, 4, 2, 1);
         begin
            repeat (30) @(posedge clk);
            #1;
            bp_hold = 1'b0;
         end
      join
      bp_active = 1'b0;
      wait_drain();

      test_name = "full_load";
      fork
         send_stream(0, 8, -1, 1);
         send_stream(1, 8, -1, 1);
         send_stream(2, 8, -1, 1);
         send_stream(3, 8, -1, 1);
      join
      wait_drain();

      $display("Errors: %0d value mismatches, %0d other failures", err_mismatch, err_other);
      if (err_mismatch == 0 && err_other == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- vlog.f
source/noc_pkg.sv
source/noc_link_if.sv
source/noc_input_buffer.sv
source/noc_router.sv
source/system_2x2_noc.sv
verif/tb_system_2x2_noc.sv
